/* hdl/iot_pkg.sv */
// shared widths and types for the byte-streaming filter

package iot_pkg;

	// --------------------
	// widths
	// --------------------
	localparam int BYTE_W = 8;   // one host byte
	localparam int ITEM_W = 128; // sixteen bytes per item
	localparam int CRC_W  = 3;   // degree of the generator
	localparam int IDX_W  = 4;   // byte index in an item

	// --------------------
	// vector types
	// --------------------
	typedef logic [BYTE_W-1:0] byte_t;
	typedef logic [ITEM_W-1:0] item_t;     // also the width of iot_out
	typedef logic [CRC_W-1:0]  crc_t;
	typedef logic [IDX_W-1:0]  byte_idx_t;

	// function codes, fixed for a whole run
	// codes 0, 1, 2, 6, 7 have no unit behind them
	typedef enum logic [2:0] {
		fn_crc = 3'd3, // crc-3 per item
		fn_max = 3'd4, // top two of a round
		fn_min = 3'd5  // last two of a round
	} fn_e;

	// generator x^3 + x^2 + 1
	// the x^3 term falls off the top of the remainder, only the low part is kept
	localparam crc_t CRC_POLY = 3'b101;

endpackage

/* hdl/byte_collector.sv */
`timescale 1ns/1ps

// assembles sixteen host bytes into one item
// first byte ends up in the top byte of item_q
module byte_collector #(
	parameter int ITEM_BYTES = 16
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              in_en,
	input  iot_pkg::byte_t    iot_in,
	output logic              byte_stb,  // registered copy of in_en
	output iot_pkg::byte_t    byte_q,    // registered copy of iot_in
	output iot_pkg::byte_idx_t byte_cnt, // bytes taken so far
	output logic              item_done, // one cycle after the last byte
	output iot_pkg::item_t    item_q
);
	import iot_pkg::*;

	logic last_byte;

	// the byte on iot_in right now closes the item
	assign last_byte = (byte_cnt == byte_idx_t'(ITEM_BYTES - 1));

	// --------------------
	// control
	// --------------------
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			byte_cnt  <= '0;
			byte_stb  <= 1'b0;
			item_done <= 1'b0;
		end else begin
			byte_stb  <= in_en;
			item_done <= in_en && last_byte;
			if (in_en) begin
				if (last_byte)
					byte_cnt <= '0; // wrap for next item
				else
					byte_cnt <= byte_cnt + 1'b1;
			end
		end
	end

	// --------------------
	// data path
	// --------------------
	// shift in from the bottom, msb byte arrives first
	always_ff @(posedge clk) begin
		if (in_en) begin
			byte_q <= iot_in;
			item_q <= {item_q[ITEM_W-BYTE_W-1:0], iot_in};
		end
	end

	// item_q may start shifting again right after item_done,
	// so consumers only get the one cycle

	// a full item needs more than one byte, done strobes are never adjacent
	a_done_single : assert property (
		@(posedge clk) disable iff (rst)
		item_done |=> !item_done
	);

endmodule

/* hdl/crc3_unit.sv */
`timescale 1ns/1ps

// crc-3 of each streamed item, msb first, eight division steps per byte
module crc3_unit (
	input  logic           clk,
	input  logic           rst,
	input  logic           enable,
	input  logic           byte_stb,
	input  iot_pkg::byte_t byte_q,
	input  logic           item_done,
	output logic           crc_valid,
	output iot_pkg::crc_t  crc
);
	import iot_pkg::*;

	crc_t rem_q;     // running remainder
	crc_t rem_byte;  // remainder with the current byte folded in
	crc_t rem_final; // after the three appended zeros

	// one long-division step, bit b shifted in at the bottom
	function automatic crc_t crc_step(crc_t r, logic b);
		crc_t nxt;
		nxt = {r[CRC_W-2:0], b};
		if (r[CRC_W-1])
			nxt = nxt ^ CRC_POLY; // x^3 term cancelled
		return nxt;
	endfunction

	always_comb begin
		rem_byte = rem_q;
		if (byte_stb) begin
			for (int i = BYTE_W - 1; i >= 0; i--)
				rem_byte = crc_step(rem_byte, byte_q[i]);
		end
		rem_final = rem_byte;
		for (int i = 0; i < CRC_W; i++)
			rem_final = crc_step(rem_final, 1'b0); // multiply by x^3
	end

	// last byte strobe and item_done share a cycle
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rem_q     <= '0;
			crc_valid <= 1'b0;
		end else begin
			crc_valid <= enable && item_done;
			if (enable && item_done)
				rem_q <= '0; // next item may already be on its first byte
			else if (enable && byte_stb)
				rem_q <= rem_byte;
		end
	end

	always_ff @(posedge clk) begin
		if (enable && item_done)
			crc <= rem_final;
	end

	a_crc_en : assert property (
		@(posedge clk) disable iff (rst)
		crc_valid |-> enable
	);

endmodule

/* hdl/rank_unit.sv */
`timescale 1ns/1ps

// keeps the best two items of a round (largest or smallest)
// and plays them out after the round's last item
module rank_unit #(
	parameter int ROUND_ITEMS = 8
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               enable,
	input  logic               min_mode,  // 1: smallest wins
	input  iot_pkg::byte_idx_t byte_cnt,
	input  logic               in_en,
	input  logic               item_done,
	input  iot_pkg::item_t     item_q,
	output logic               rank_valid,
	output iot_pkg::item_t     rank_item,
	output logic               rank_busy
);
	import iot_pkg::*;

	localparam int RW = (ROUND_ITEMS > 2) ? $clog2(ROUND_ITEMS) : 1;

	typedef enum logic [1:0] {
		rank_collect,
		rank_send_best,
		rank_send_second,
		rank_clear
	} rank_state_e;

	rank_state_e   state_q;
	logic [RW-1:0] round_cnt; // items of this round already ranked
	logic          last_item; // item in flight is the round's last
	logic          last_byte; // byte on the bus closes an item

	item_t best_q;
	item_t second_q;
	item_t ident;        // starting value of both bests
	logic  beats_best;   // strictly better than best
	logic  beats_second; // strictly better than second

	assign last_item = (round_cnt == RW'(ROUND_ITEMS - 1));
	assign last_byte = &byte_cnt;

	// --------------------
	// compare
	// --------------------
	// whole item compared in one go, unsigned
	always_comb begin
		ident = min_mode ? '1 : '0;
		if (min_mode) begin
			beats_best   = (item_q < best_q);
			beats_second = (item_q < second_q);
		end else begin
			beats_best   = (item_q > best_q);
			beats_second = (item_q > second_q);
		end
	end

	// --------------------
	// control fsm
	// --------------------
	// reset parks in rank_clear so the bests pick up their identity
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state_q    <= rank_clear;
			round_cnt  <= '0;
			rank_busy  <= 1'b0;
			rank_valid <= 1'b0;
		end else begin
			rank_valid <= 1'b0;
			case (state_q)
				rank_collect: begin
					// raise the stall with the last byte of the round
					if (enable && in_en && last_byte && last_item)
						rank_busy <= 1'b1;
					if (enable && item_done) begin
						if (last_item) begin
							round_cnt <= '0;
							state_q   <= rank_send_best;
						end else begin
							round_cnt <= round_cnt + 1'b1;
						end
					end
				end
				rank_send_best: begin
					rank_valid <= 1'b1; // best goes out
					state_q    <= rank_send_second;
				end
				rank_send_second: begin
					rank_valid <= 1'b1; // second goes out
					state_q    <= rank_clear;
				end
				rank_clear: begin
					rank_busy <= 1'b0; // host may resume
					state_q   <= rank_collect;
				end
				default: state_q <= rank_clear;
			endcase
		end
	end

	// --------------------
	// item storage
	// --------------------
	always_ff @(posedge clk) begin
		case (state_q)
			rank_collect: begin
				if (enable && item_done) begin
					if (beats_best) begin
						second_q <= best_q; // old best moves down
						best_q   <= item_q;
					end else if (beats_second) begin
						second_q <= item_q;
					end
					// ties leave both places alone
				end
			end
			rank_send_best:   rank_item <= best_q;
			rank_send_second: rank_item <= second_q;
			rank_clear: begin
				best_q   <= ident;
				second_q <= ident;
			end
			default: ;
		endcase
	end

	// stall is E0 up to the second result, nothing longer
	a_busy_len : assert property (
		@(posedge clk) disable iff (rst)
		rank_busy [*4] |=> !rank_busy
	);

	a_valid_en : assert property (
		@(posedge clk) disable iff (rst)
		rank_valid |-> enable
	);

endmodule

/* hdl/iot_filter.sv */
`timescale 1ns/1ps

// byte-streaming filter top: crc-3, top-two max, last-two min
module iot_filter #(
	parameter int ITEM_BYTES  = 16,
	parameter int ROUND_ITEMS = 8
) (
	input  logic           clk,
	input  logic           rst,
	input  logic           in_en,
	input  iot_pkg::byte_t iot_in,
	input  logic [2:0]     fn_sel,
	output logic           busy,
	output logic           valid,
	output iot_pkg::item_t iot_out
);
	import iot_pkg::*;

	fn_e fn_q;      // function code, stable for the run
	logic crc_en;
	logic rank_en;
	logic min_mode;

	logic      byte_stb;
	byte_t     byte_q;
	byte_idx_t byte_cnt;
	logic      item_done;
	item_t     item_q;

	logic  crc_valid;
	crc_t  crc;
	logic  rank_valid;
	item_t rank_item;
	logic  rank_busy;

	// --------------------
	// function select
	// --------------------
	// loads during reset too, so the rank unit sees min_mode before the first item
	always_ff @(posedge clk) begin
		fn_q <= fn_e'(fn_sel);
	end

	assign crc_en   = (fn_q == fn_crc);
	assign rank_en  = (fn_q == fn_max) || (fn_q == fn_min);
	assign min_mode = (fn_q == fn_min);

	// --------------------
	// units
	// --------------------
	byte_collector #(.ITEM_BYTES(ITEM_BYTES)) i_collect (
		.clk(clk), .rst(rst), .in_en(in_en), .iot_in(iot_in),
		.byte_stb(byte_stb), .byte_q(byte_q), .byte_cnt(byte_cnt),
		.item_done(item_done), .item_q(item_q)
	);

	crc3_unit i_crc (
		.clk(clk), .rst(rst), .enable(crc_en),
		.byte_stb(byte_stb), .byte_q(byte_q), .item_done(item_done),
		.crc_valid(crc_valid), .crc(crc)
	);

	rank_unit #(.ROUND_ITEMS(ROUND_ITEMS)) i_rank (
		.clk(clk), .rst(rst), .enable(rank_en), .min_mode(min_mode),
		.byte_cnt(byte_cnt), .in_en(in_en), .item_done(item_done),
		.item_q(item_q), .rank_valid(rank_valid), .rank_item(rank_item),
		.rank_busy(rank_busy)
	);

	// --------------------
	// outputs
	// --------------------
	assign busy = rank_busy; // already a flop, rises at E0 of the round's last item

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			valid <= 1'b0;
		else
			valid <= crc_valid || rank_valid; // only the enabled unit strobes
	end

	always_ff @(posedge clk) begin
		if (crc_valid)
			iot_out <= item_t'(crc); // zero-extended
		else if (rank_valid)
			iot_out <= rank_item;
	end

	// host reads busy at the edge it drives in_en
	a_no_byte_while_busy : assert property (
		@(posedge clk) disable iff (rst)
		in_en |-> !$past(busy)
	);

endmodule

/* dv/tb_ref.svh */
`ifndef TB_REF_SVH
`define TB_REF_SVH

// --------------------
// crc reference
// --------------------
// long division of item * x^3 by x^3 + x^2 + 1, whole dividend at once
function automatic crc_t ref_crc3(input item_t item);
	logic [ITEM_W+2:0] dividend;
	dividend = {item, 3'b000}; // append three zeros
	for (int i = ITEM_W + 2; i >= 3; i--) begin
		if (dividend[i])
			dividend[i -: 4] = dividend[i -: 4] ^ 4'b1101; // subtract the generator
	end
	return dividend[2:0];
endfunction

// --------------------
// round reference
// --------------------
// a outranks b, strict
function automatic logic is_better(input item_t a, input item_t b, input logic min_mode);
	return min_mode ? (a < b) : (a > b);
endfunction

// best of the round, then best of the rest with one copy of the winner removed
function automatic void ref_rank(input item_t items [N_ROUND], input logic min_mode,
		output item_t best, output item_t second);
	int best_i;
	int sec_i;
	best_i = 0;
	sec_i  = -1;
	for (int i = 1; i < N_ROUND; i++) begin
		if (is_better(items[i], items[best_i], min_mode))
			best_i = i;
	end
	for (int i = 0; i < N_ROUND; i++) begin
		if (i != best_i) begin
			if (sec_i < 0)
				sec_i = i; // first candidate
			else if (is_better(items[i], items[sec_i], min_mode))
				sec_i = i;
		end
	end
	best   = items[best_i];
	second = items[sec_i]; // duplicates of the best land here
endfunction

`endif

/* dv/tb_iot_filter.sv */
`timescale 1ns/1ps

module tb_iot_filter;
	import iot_pkg::*;

	localparam int ITEM_BYTES    = 16;
	localparam int N_ROUND       = 8;
	localparam int SEED          = 12093;
	localparam int N_CRC_ITEMS   = 20;
	localparam int N_GAP_ITEMS   = 10;
	localparam int N_RANK_ROUNDS = 3;
	localparam int BUSY_TIMEOUT  = 50;  // cycles
	localparam int VALID_TIMEOUT = 200; // cycles

	`include "tb_ref.svh"

	logic       clk;
	logic       rst;
	logic       in_en;
	byte_t      iot_in;
	logic [2:0] fn_sel;
	logic       busy;
	logic       valid;
	item_t      iot_out;

	item_t exp_q[$];   // results still owed by the DUT
	string test_name;
	int    n_checked;
	int    busy_run;   // consecutive busy cycles
	logic  second_due; // second result owed right after the best
	logic  rank_mode;

	iot_filter #(.ITEM_BYTES(ITEM_BYTES), .ROUND_ITEMS(N_ROUND)) i_dut (
		.clk(clk), .rst(rst), .in_en(in_en), .iot_in(iot_in), .fn_sel(fn_sel),
		.busy(busy), .valid(valid), .iot_out(iot_out)
	);

	always #4 clk = ~clk; // 8 ns period

	// --------------------
	// error handling
	// --------------------
	task automatic abort_run();
		$display(">>> FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input item_t expected, input item_t actual);
		if (expected !== actual) begin
			$display("FAILED %s expected %h actual %h", name, expected, actual);
			abort_run();
		end
	endtask

	// --------------------
	// stimulus helpers
	// --------------------
	function automatic item_t rand_item();
		return {$urandom, $urandom, $urandom, $urandom};
	endfunction

	task automatic reset_dut(input logic [2:0] code);
		@(posedge clk);
		rst    <= 1'b1;
		in_en  <= 1'b0;
		iot_in <= '0;
		fn_sel <= code; // held for the whole phase
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check_value({test_name, " busy after reset"}, '0, item_t'(busy));
		check_value({test_name, " valid after reset"}, '0, item_t'(valid));
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			in_en <= 1'b0;
		end
	endtask

	// busy read at the edge and the byte taken at the next one
	task automatic send_byte(input byte_t b);
		int waited;
		waited = 0;
		@(posedge clk);
		while (busy) begin
			in_en <= 1'b0;
			waited++;
			if (waited > BUSY_TIMEOUT) begin
				$display("timed out waiting for busy to drop before a byte");
				abort_run();
			end
			@(posedge clk);
		end
		in_en  <= 1'b1;
		iot_in <= b;
	endtask

	// msb byte first with random idle cycles only between bytes
	task automatic send_item(input item_t item, input int max_gap);
		for (int i = ITEM_BYTES - 1; i >= 0; i--) begin
			send_byte(item[i*8 +: 8]);
			if (max_gap > 0 && i > 0)
				idle_cycles($urandom_range(max_gap, 0));
		end
	endtask

	task automatic wait_busy(input logic level, input string what);
		int waited;
		waited = 0;
		@(posedge clk);
		while (busy !== level) begin
			waited++;
			if (waited > BUSY_TIMEOUT) begin
				$display("timed out: %s", what);
				abort_run();
			end
			@(posedge clk);
		end
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (exp_q.size() != 0) begin
			waited++;
			if (waited > VALID_TIMEOUT) begin
				$display("timed out waiting for valid in %s", test_name);
				abort_run();
			end
			@(posedge clk);
		end
	endtask

	task automatic run_crc_phase(input string name, input int n_items, input int max_gap);
		item_t item;
		test_name = name;
		rank_mode = 1'b0;
		reset_dut(3'd3);
		for (int n = 0; n < n_items; n++) begin
			item = rand_item();
			exp_q.push_back(item_t'(ref_crc3(item))); // upper bits must be zero
			send_item(item, max_gap);
		end
		idle_cycles(1);
		wait_drain();
	endtask

	task automatic run_rank_phase(input logic [2:0] code, input string name);
		item_t items [N_ROUND];
		item_t best;
		item_t second;
		int    m;
		test_name = name;
		rank_mode = 1'b1;
		reset_dut(code);
		for (int r = 0; r < N_RANK_ROUNDS; r++) begin
			for (int i = 0; i < N_ROUND; i++)
				items[i] = rand_item();
			if (code == 3'd5) begin
				items[2] = '1;                  // all ones never wins a min round
				items[1] = item_t'($urandom);   // very likely the minimum
				m = 1;
				for (int i = 0; i < N_ROUND; i++) begin
					if (i != 6 && items[i] < items[m])
						m = i;
				end
				items[6] = items[m]; // tie with the minimum
			end
			for (int i = 0; i < N_ROUND; i++)
				send_item(items[i], r);
			ref_rank(items, code == 3'd5, best, second);
			exp_q.push_back(best);
			exp_q.push_back(second);
			idle_cycles(1);
			wait_busy(1'b1, "busy did not rise after the last item of the round");
			wait_busy(1'b0, "busy did not fall after the round results");
			wait_drain();
		end
	endtask

	// --------------------
	// compare process
	// --------------------
	// outputs sampled mid-cycle away from the edges
	always @(negedge clk) begin
		if (rst) begin
			busy_run   = 0;
			second_due = 1'b0;
		end else begin
			if (busy)
				busy_run++;
			else
				busy_run = 0;
			if (busy_run > 4) begin
				$display("busy stayed high for more than four cycles in %s", test_name);
				abort_run();
			end
			if (busy && !rank_mode) begin
				$display("busy went high during a crc phase");
				abort_run();
			end
			if (second_due && !valid) begin
				$display("second result did not follow the best in %s", test_name);
				abort_run();
			end
			if (valid) begin
				if (exp_q.size() == 0) begin
					$display("valid with no result pending in %s", test_name);
					abort_run();
				end else begin
					check_value(test_name, exp_q.pop_front(), iot_out);
					n_checked++;
					if (rank_mode)
						second_due = !second_due;
				end
			end
		end
	end

	// --------------------
	// main sequence
	// --------------------
	initial begin
		void'($urandom(SEED));
		clk        = 1'b0;
		rst        = 1'b1;
		in_en      = 1'b0;
		iot_in     = '0;
		fn_sel     = 3'd3;
		n_checked  = 0;
		busy_run   = 0;
		second_due = 1'b0;
		rank_mode  = 1'b0;
		test_name  = "startup";

		run_crc_phase("crc_back_to_back", N_CRC_ITEMS, 0);
		run_crc_phase("crc_with_gaps", N_GAP_ITEMS, 3);
		run_rank_phase(3'd4, "top_two_max");
		run_rank_phase(3'd5, "last_two_min");
		idle_cycles(2);

		$display("%0d results checked", n_checked);
		$display(">>> PASS");
		$finish;
	end

endmodule

/* all.f */
+incdir+dv
hdl/iot_pkg.sv
hdl/byte_collector.sv
hdl/crc3_unit.sv
hdl/rank_unit.sv
hdl/iot_filter.sv
dv/tb_iot_filter.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_iot_filter
FLIST     ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= >>> PASS

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST) $(wildcard hdl/*.sv) $(wildcard dv/*.sv) $(wildcard dv/*.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
